// File: apb_sb_pwm.f
hw/apb_sb_pkg.sv
hw/apb_to_simplebus.sv
hw/pwm_regs.sv
hw/pwm_gen.sv
hw/apb_sb_pwm_top.sv
verification/apb_sb_pwm_assertions.sv
verification/tb_apb_sb_pwm.sv

// File: Bender.yml
package:
  name: apb_sb_pwm

sources:
  # RTL in compile order
  - hw/apb_sb_pkg.sv
  - hw/apb_to_simplebus.sv
  - hw/pwm_regs.sv
  - hw/pwm_gen.sv
  - hw/apb_sb_pwm_top.sv

  # Verification sources
  - target: test
    files:
      - verification/apb_sb_pwm_assertions.sv
      - verification/tb_apb_sb_pwm.sv

// File: verification/tb_apb_sb_pwm.sv
// Testbench for the APB PWM peripheral with APB driver tasks, directed tests and typed compares
`timescale 1ns/100ps

module tb_apb_sb_pwm;

    localparam int PREADY_TIMEOUT = 20;

    logic                   PCLK;
    logic                   PRESETn;
    apb_sb_pkg::apb_req_t   apb_req;
    apb_sb_pkg::apb_rsp_t   apb_rsp;
    logic                   pwm_out;

    int     errors;
    int     assert_errors;
    bit     timed_out;
    integer seed;
    // Longest period the generator may still be running before the next settle
    int     slow_period;

    // Expected register contents, updated on every mapped write
    logic [apb_sb_pkg::DATA_W-1:0] model_ctrl;
    logic [apb_sb_pkg::DATA_W-1:0] model_period;
    logic [apb_sb_pkg::DATA_W-1:0] model_duty;

    apb_sb_pwm_top dut (
        .PCLK    (PCLK),
        .PRESETn (PRESETn),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .pwm_out (pwm_out)
    );

    initial begin
        PCLK = 1'b0;
        forever #4 PCLK = ~PCLK;
    end

    task automatic check_rsp(input string name, input apb_sb_pkg::apb_rsp_t actual,
                             input apb_sb_pkg::apb_rsp_t expected);
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: got prdata %h pready %h, expected prdata %h pready %h",
                     name, actual.prdata, actual.pready, expected.prdata, expected.pready);
        end
    endtask

    task automatic check_pwm(input string name,
                             input logic [apb_sb_pkg::CNT_W-1:0] high,
                             input logic [apb_sb_pkg::CNT_W-1:0] total,
                             input logic [apb_sb_pkg::CNT_W-1:0] exp_high,
                             input logic [apb_sb_pkg::CNT_W-1:0] exp_total);
        if (high !== exp_high || total !== exp_total) begin
            errors++;
            $display("FAILED %s: got high %h of %h cycles, expected high %h of %h cycles",
                     name, high, total, exp_high, exp_total);
        end
    endtask

    task automatic check_latency(input string name, input int actual, input int expected);
        if (actual != expected) begin
            errors++;
            $display("FAILED %s: got %h low cycles, expected %h", name, actual, expected);
        end
    endtask

    task automatic report_timeout(input string kind, input logic [31:0] addr);
        timed_out = 1'b1;
        errors++;
        $display("PREADY never returned high during the APB %s to address %h", kind, addr);
    endtask

    task automatic apb_write(input logic [apb_sb_pkg::ADDR_W-1:0] addr,
                             input logic [apb_sb_pkg::DATA_W-1:0] data);
        int waited;
        waited = 0;
        if (timed_out) begin
            return;
        end
        @(posedge PCLK);
        apb_req.paddr   <= addr;
        apb_req.pwrite  <= 1'b1;
        apb_req.pwdata  <= data;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        @(posedge PCLK);
        apb_req.penable <= 1'b1;
        @(negedge PCLK);
        while (!apb_rsp.pready && waited < PREADY_TIMEOUT) begin
            waited++;
            @(negedge PCLK);
        end
        if (!apb_rsp.pready) begin
            report_timeout("write", addr);
        end
        @(posedge PCLK);
        apb_req <= '0;
    endtask

    // Returns the response seen when PREADY is high and the number of stalled cycles
    task automatic apb_read(input logic [apb_sb_pkg::ADDR_W-1:0] addr,
                            output apb_sb_pkg::apb_rsp_t rsp, output int low);
        rsp = '0;
        low = 0;
        if (timed_out) begin
            return;
        end
        @(posedge PCLK);
        apb_req.paddr   <= addr;
        apb_req.pwrite  <= 1'b0;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        @(posedge PCLK);
        apb_req.penable <= 1'b1;
        @(negedge PCLK);
        while (!apb_rsp.pready && low < PREADY_TIMEOUT) begin
            low++;
            @(negedge PCLK);
        end
        if (!apb_rsp.pready) begin
            report_timeout("read", addr);
        end
        rsp = apb_rsp;
        @(posedge PCLK);
        apb_req <= '0;
    endtask

    task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
        apb_write(addr, data);
        case (addr)
            apb_sb_pkg::REG_CTRL:   model_ctrl = {31'b0, data[0]};
            apb_sb_pkg::REG_PERIOD: begin
                model_period = {16'b0, data[15:0]};
                if (int'(data[15:0]) > slow_period) begin
                    slow_period = int'(data[15:0]);
                end
            end
            apb_sb_pkg::REG_DUTY:   model_duty = {16'b0, data[15:0]};
            default: ;
        endcase
    endtask

    // Every read stalls for the latency count plus the cycle that loads it
    task automatic read_and_check(input string name, input logic [31:0] addr,
                                  input logic [31:0] expected);
        apb_sb_pkg::apb_rsp_t rsp;
        apb_sb_pkg::apb_rsp_t exp_rsp;
        int                   low;
        apb_read(addr, rsp, low);
        exp_rsp.prdata = expected;
        exp_rsp.pready = 1'b1;
        check_rsp(name, rsp, exp_rsp);
        check_latency({name, " PREADY"}, low, apb_sb_pkg::READ_LATENCY + 1);
    endtask

    task automatic measure_pwm(input logic [apb_sb_pkg::CNT_W-1:0] cycles,
                               output logic [apb_sb_pkg::CNT_W-1:0] high,
                               output logic [apb_sb_pkg::CNT_W-1:0] total);
        high = '0;
        total = '0;
        repeat (cycles) begin
            @(negedge PCLK);
            total++;
            if (pwm_out) begin
                high++;
            end
        end
    endtask

    // New settings load at the next wrap of the old period, then two full periods pass
    task automatic set_pwm(input logic [15:0] period, input logic [15:0] duty, input bit en);
        int p_new;
        reg_write(apb_sb_pkg::REG_PERIOD, {16'b0, period});
        reg_write(apb_sb_pkg::REG_DUTY, {16'b0, duty});
        reg_write(apb_sb_pkg::REG_CTRL, {31'b0, en});
        p_new = (period < 1) ? 1 : int'(period);
        repeat (slow_period + 1 + 2 * p_new + 4) @(posedge PCLK);
        slow_period = int'(period);
    endtask

    task automatic test_reset_state();
        apb_sb_pkg::apb_rsp_t          exp_rsp;
        logic [apb_sb_pkg::CNT_W-1:0]  high;
        logic [apb_sb_pkg::CNT_W-1:0]  total;
        exp_rsp = '0;
        exp_rsp.pready = 1'b1;
        @(negedge PCLK);
        check_rsp("apb_rsp after reset", apb_rsp, exp_rsp);
        measure_pwm(16'd64, high, total);
        check_pwm("pwm_out after reset", high, total, 16'd0, 16'd64);
    endtask

    task automatic test_register_roundtrip();
        reg_write(apb_sb_pkg::REG_PERIOD, $random(seed));
        reg_write(apb_sb_pkg::REG_DUTY, $random(seed));
        reg_write(apb_sb_pkg::REG_CTRL, $random(seed));
        read_and_check("apb_rsp CTRL", apb_sb_pkg::REG_CTRL, model_ctrl);
        read_and_check("apb_rsp PERIOD", apb_sb_pkg::REG_PERIOD, model_period);
        read_and_check("apb_rsp DUTY", apb_sb_pkg::REG_DUTY, model_duty);
    endtask

    task automatic test_unmapped_access();
        read_and_check("apb_rsp unmapped 0x0c", 32'h0000_000c, 32'h0);
        read_and_check("apb_rsp unmapped 0x100", 32'h0000_0100, 32'h0);
        // Full address decode, so an upper bit set must not alias onto PERIOD
        apb_write(32'h0000_0010, $random(seed));
        apb_write(32'h4000_0004, $random(seed));
        read_and_check("apb_rsp CTRL kept", apb_sb_pkg::REG_CTRL, model_ctrl);
        read_and_check("apb_rsp PERIOD kept", apb_sb_pkg::REG_PERIOD, model_period);
        read_and_check("apb_rsp DUTY kept", apb_sb_pkg::REG_DUTY, model_duty);
    endtask

    task automatic test_pwm_duty();
        logic [31:0]                   rnd;
        logic [apb_sb_pkg::CNT_W-1:0]  p;
        logic [apb_sb_pkg::CNT_W-1:0]  d;
        logic [apb_sb_pkg::CNT_W-1:0]  high;
        logic [apb_sb_pkg::CNT_W-1:0]  total;
        repeat (3) begin
            rnd = $random(seed);
            p = 16'd8 + {11'b0, rnd[4:0]};
            d = 16'd1 + (rnd[31:16] % (p - 16'd1));
            set_pwm(p, d, 1'b1);
            measure_pwm(p, high, total);
            check_pwm("pwm_out duty", high, total, d, p);
        end
    endtask

    task automatic test_saturation_disable();
        logic [apb_sb_pkg::CNT_W-1:0]  high;
        logic [apb_sb_pkg::CNT_W-1:0]  total;
        set_pwm(16'd10, 16'd10, 1'b1);
        measure_pwm(16'd10, high, total);
        check_pwm("pwm_out duty equal period", high, total, 16'd10, 16'd10);
        set_pwm(16'd10, 16'd17, 1'b1);
        measure_pwm(16'd10, high, total);
        check_pwm("pwm_out duty above period", high, total, 16'd10, 16'd10);
        reg_write(apb_sb_pkg::REG_CTRL, 32'h0);
        repeat (12) @(posedge PCLK);
        measure_pwm(16'd10, high, total);
        check_pwm("pwm_out disabled", high, total, 16'd0, 16'd10);
    endtask

    initial begin
        apb_req      = '0;
        PRESETn      = 1'b0;
        errors       = 0;
        timed_out    = 1'b0;
        seed         = 32'hd9435e9b;
        slow_period  = 0;
        model_ctrl   = '0;
        model_period = '0;
        model_duty   = '0;
        repeat (5) @(posedge PCLK);
        PRESETn <= 1'b1;
        @(posedge PCLK);

        test_reset_state();
        test_register_roundtrip();
        test_unmapped_access();
        test_pwm_duty();
        test_saturation_disable();

        repeat (2) @(posedge PCLK);
        assert_errors = dut.u_bridge.u_assertions.fail_count;
        $display("Errors: %0d check failures, %0d assertion failures", errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verification/apb_sb_pwm_assertions.sv
// Concurrent bus-protocol assertions for the APB to Simplebus bridge, attached with bind
`timescale 1ns/100ps

module apb_sb_pwm_assertions (
    input logic                 PCLK,
    input logic                 PRESETn,
    input apb_sb_pkg::apb_req_t apb_req,
    input apb_sb_pkg::apb_rsp_t apb_rsp,
    input apb_sb_pkg::sb_req_t  sb_req
);

    localparam int LAT = apb_sb_pkg::READ_LATENCY;

    // Number of assertion failures, collected by the testbench at the end of the run
    int fail_count = 0;

    strobes_exclusive: assert property (@(posedge PCLK) disable iff (!PRESETn)
        !(sb_req.read_strobe && sb_req.write_strobe))
        else begin
            fail_count++;
            $error("Read and write strobes are high in the same cycle");
        end

    // A Simplebus strobe may only come from an APB setup phase
    strobe_in_setup: assert property (@(posedge PCLK) disable iff (!PRESETn)
        (sb_req.read_strobe || sb_req.write_strobe) |-> (apb_req.psel && !apb_req.penable))
        else begin
            fail_count++;
            $error("Simplebus strobe outside an APB setup phase");
        end

    // PREADY stays low for the latency count plus the load cycle, then rises
    read_stall_length: assert property (@(posedge PCLK) disable iff (!PRESETn)
        $fell(apb_rsp.pready) |-> ##1 (!apb_rsp.pready)[*LAT] ##1 apb_rsp.pready)
        else begin
            fail_count++;
            $error("PREADY did not rise the expected number of edges after it fell");
        end

endmodule

bind apb_to_simplebus apb_sb_pwm_assertions u_assertions (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .sb_req  (sb_req)
);

// File: hw/apb_sb_pwm_top.sv
// Top level of the PWM peripheral joining the APB bridge, register bank and generator
`timescale 1ns/100ps

module apb_sb_pwm_top (
    input  logic                    PCLK,
    input  logic                    PRESETn,
    input  apb_sb_pkg::apb_req_t    apb_req,
    output apb_sb_pkg::apb_rsp_t    apb_rsp,
    output logic                    pwm_out
);

    apb_sb_pkg::sb_req_t            sb_req;
    logic [apb_sb_pkg::DATA_W-1:0]  sb_read_data;
    apb_sb_pkg::pwm_cfg_t           cfg;

    apb_to_simplebus u_bridge (
        .PCLK         (PCLK),
        .PRESETn      (PRESETn),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .sb_req       (sb_req),
        .sb_read_data (sb_read_data)
    );

    pwm_regs u_regs (
        .PCLK         (PCLK),
        .PRESETn      (PRESETn),
        .sb_req       (sb_req),
        .sb_read_data (sb_read_data),
        .cfg          (cfg)
    );

    pwm_gen u_gen (
        .PCLK         (PCLK),
        .PRESETn      (PRESETn),
        .cfg          (cfg),
        .pwm_out      (pwm_out)
    );

endmodule

// File: hw/pwm_gen.sv
// PWM counter with shadowed configuration and a registered output pin
`timescale 1ns/100ps

module pwm_gen (
    input  logic                    PCLK,
    input  logic                    PRESETn,
    input  apb_sb_pkg::pwm_cfg_t    cfg,
    output logic                    pwm_out
);

    apb_sb_pkg::pwm_cfg_t           shadow;
    logic [apb_sb_pkg::CNT_W-1:0]   cnt;
    logic [apb_sb_pkg::CNT_W-1:0]   last;
    logic                           wrap;

    // Period of zero behaves like a period of one
    assign last = (shadow.period <= 1) ? '0 : shadow.period - 1'b1;
    assign wrap = (cnt >= last);

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            shadow  <= '0;
            cnt     <= '0;
            pwm_out <= 1'b0;
        end else begin
            // New settings are picked up only at the period boundary
            if (wrap) begin
                cnt    <= '0;
                shadow <= cfg;
            end else begin
                cnt <= cnt + 1'b1;
            end
            // Duty at or above the period keeps the pin high for the whole period
            pwm_out <= shadow.enable && (cnt < shadow.duty);
        end
    end

endmodule

// File: hw/pwm_regs.sv
// Simplebus register bank with control, period and duty registers and registered read data
`timescale 1ns/100ps

module pwm_regs (
    input  logic                            PCLK,
    input  logic                            PRESETn,
    input  apb_sb_pkg::sb_req_t             sb_req,
    output logic [apb_sb_pkg::DATA_W-1:0]   sb_read_data,
    output apb_sb_pkg::pwm_cfg_t            cfg
);

    apb_sb_pkg::pwm_cfg_t           cfg_q;
    logic [apb_sb_pkg::DATA_W-1:0]  rd_mux;
    logic [apb_sb_pkg::DATA_W-1:0]  rd_data_q;

    // Read multiplexer, fields are zero extended and unmapped addresses read as zero
    always_comb begin
        rd_mux = '0;
        case (sb_req.address)
            apb_sb_pkg::REG_CTRL: begin
                rd_mux[apb_sb_pkg::CTRL_EN_BIT] = cfg_q.enable;
            end
            apb_sb_pkg::REG_PERIOD: begin
                rd_mux[apb_sb_pkg::CNT_W-1:0] = cfg_q.period;
            end
            apb_sb_pkg::REG_DUTY: begin
                rd_mux[apb_sb_pkg::CNT_W-1:0] = cfg_q.duty;
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            cfg_q     <= '0;
            rd_data_q <= '0;
        end else begin
            if (sb_req.write_strobe) begin
                // Upper bits of the write data beyond each field are dropped
                case (sb_req.address)
                    apb_sb_pkg::REG_CTRL: begin
                        cfg_q.enable <= sb_req.write_data[apb_sb_pkg::CTRL_EN_BIT];
                    end
                    apb_sb_pkg::REG_PERIOD: begin
                        cfg_q.period <= sb_req.write_data[apb_sb_pkg::CNT_W-1:0];
                    end
                    apb_sb_pkg::REG_DUTY: begin
                        cfg_q.duty <= sb_req.write_data[apb_sb_pkg::CNT_W-1:0];
                    end
                    default: begin
                        cfg_q <= cfg_q;
                    end
                endcase
            end
            // Read data is held until the next read strobe
            if (sb_req.read_strobe) begin
                rd_data_q <= rd_mux;
            end
        end
    end

    assign sb_read_data = rd_data_q;
    assign cfg          = cfg_q;

endmodule

// File: hw/apb_to_simplebus.sv
// APB slave that turns setup phases into Simplebus strobes and stalls reads for a fixed latency
`timescale 1ns/100ps

module apb_to_simplebus (
    input  logic                            PCLK,
    input  logic                            PRESETn,
    input  apb_sb_pkg::apb_req_t            apb_req,
    output apb_sb_pkg::apb_rsp_t            apb_rsp,
    output apb_sb_pkg::sb_req_t             sb_req,
    input  logic [apb_sb_pkg::DATA_W-1:0]   sb_read_data
);

    logic [1:0]                     state;
    logic [apb_sb_pkg::LAT_W-1:0]   lat_cnt;
    logic [apb_sb_pkg::DATA_W-1:0]  prdata_q;
    logic                           pready_q;
    logic                           setup_phase;

    // An APB setup phase is PSEL high with PENABLE still low
    assign setup_phase = apb_req.psel & ~apb_req.penable;

    // Strobes last exactly the setup cycle, everything else is held at zero
    always_comb begin
        sb_req = '0;
        if (setup_phase) begin
            sb_req.address = apb_req.paddr;
            if (apb_req.pwrite) begin
                sb_req.write_strobe = 1'b1;
                sb_req.write_data   = apb_req.pwdata;
            end else begin
                sb_req.read_strobe = 1'b1;
            end
        end
    end

    // Writes complete with PREADY left high, so only reads leave the idle state
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            state    <= apb_sb_pkg::ST_IDLE;
            pready_q <= 1'b1;
            lat_cnt  <= apb_sb_pkg::LAT_LOAD;
            prdata_q <= '0;
        end else begin
            case (state)
                apb_sb_pkg::ST_IDLE: begin
                    if (setup_phase && !apb_req.pwrite) begin
                        state    <= apb_sb_pkg::ST_WAIT;
                        pready_q <= 1'b0;
                        lat_cnt  <= apb_sb_pkg::LAT_LOAD;
                    end
                end
                apb_sb_pkg::ST_WAIT: begin
                    // Register bank data has settled by the time the counter runs out
                    if (lat_cnt == '0) begin
                        prdata_q <= sb_read_data;
                        pready_q <= 1'b1;
                        state    <= apb_sb_pkg::ST_IDLE;
                    end else begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                end
                default: begin
                    // Recover from an illegal encoding
                    state    <= apb_sb_pkg::ST_IDLE;
                    pready_q <= 1'b1;
                    lat_cnt  <= apb_sb_pkg::LAT_LOAD;
                end
            endcase
        end
    end

    assign apb_rsp.prdata = prdata_q;
    assign apb_rsp.pready = pready_q;

endmodule

// File: hw/apb_sb_pkg.sv
// Package with bus widths, bridge FSM encoding, PWM register map and bus structs
package apb_sb_pkg;

    // Bus and field widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int CNT_W  = 16;

    // Wait cycles the bridge counts before it samples the read data
    localparam int READ_LATENCY = 2;

    // Sized one step above the latency so the counter never collapses to zero bits
    localparam int LAT_W = $clog2(READ_LATENCY + 2);
    localparam logic [LAT_W-1:0] LAT_LOAD = READ_LATENCY[LAT_W-1:0];

    // One-hot states of the bridge FSM
    localparam logic [1:0] ST_IDLE = 2'b01;
    localparam logic [1:0] ST_WAIT = 2'b10;

    // Byte addresses of the PWM registers
    localparam logic [ADDR_W-1:0] REG_CTRL   = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] REG_PERIOD = 32'h0000_0004;
    localparam logic [ADDR_W-1:0] REG_DUTY   = 32'h0000_0008;

    // Enable bit position inside the control register
    localparam int CTRL_EN_BIT = 0;

    typedef struct packed {
        logic [ADDR_W-1:0] paddr;
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
    } apb_rsp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] address;
        logic              read_strobe;
        logic              write_strobe;
        logic [DATA_W-1:0] write_data;
    } sb_req_t;

    // Configuration handed from the register bank to the generator
    typedef struct packed {
        logic             enable;
        logic [CNT_W-1:0] period;
        logic [CNT_W-1:0] duty;
    } pwm_cfg_t;

endpackage
